// File: design/tag_client_recv.sv
// single clock domain, no synchronizer; data is stable between new_val pulses
// client_reset follows the registered reset code, shift the value in before it drops
`timescale 1ns/1ps
`include "tag_net_consts.svh"

module tag_client_recv
   (
      input  logic                             bsg_tag_i,
      input  logic                             reset_i,
      input  tag_line_pkg::tag_line_s          line_i,
      input  logic [`TAG_CLIENT_W-1:0]         data_async_i,
      output tag_line_pkg::tag_client_out_s    client_o
   );

   // local copy of the line, in step with the unsync stage's copy
   logic op_r;
   logic param_r;

   // a shift op was seen last cycle
   logic shift_run_r;

   logic new_val_r;
   logic [`TAG_CLIENT_W-1:0] data_r;

   // first idle cycle after a run of shifts
   // unsync data has settled by now
   wire run_end = ~op_r & shift_run_r;

   // reset code as seen on the registered line
   wire reset_code = ~op_r & param_r;

   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
      begin
         op_r        <= 1'b0;
         param_r     <= 1'b0;
         shift_run_r <= 1'b0;
         new_val_r   <= 1'b0;
      end
      else
      begin
         op_r        <= line_i.op;
         param_r     <= line_i.param;
         shift_run_r <= op_r;
         new_val_r   <= run_end;
      end
   end

   // published value only moves at the end of a run
   always_ff @(posedge bsg_tag_i)
   begin
      if (run_end)
         data_r <= data_async_i;
   end

   assign client_o.data         = data_r;
   assign client_o.new_val      = new_val_r;
   assign client_o.client_reset = reset_code;

   // a reset sequence and a data update never overlap at the client
   a_no_val_in_reset: assert property (@(posedge bsg_tag_i) disable iff (reset_i)
      !(new_val_r && reset_code))
      else $error("new_val and client_reset high together");

   // one pulse per shift run
   a_val_pulse: assert property (@(posedge bsg_tag_i) disable iff (reset_i)
      new_val_r |=> !new_val_r)
      else $error("new_val held for more than one cycle");

endmodule

// File: design/tag_client_unsync.sv
// raw shift register, intermediate values are visible while shifting
// no reset, so contents are unknown until a full width has been shifted in
`timescale 1ns/1ps
`include "tag_net_consts.svh"

module tag_client_unsync
   (
      input  logic                       bsg_tag_i,
      input  tag_line_pkg::tag_line_s    line_i,
      output logic [`TAG_CLIENT_W-1:0]   data_async_r_o
   );

   localparam int width_lp = `TAG_CLIENT_W;

   // line registered once before use
   logic op_r;
   logic param_r;

   logic [width_lp-1:0] data_r;
   logic [width_lp-1:0] data_shift;

   always_ff @(posedge bsg_tag_i)
   begin
      op_r    <= line_i.op;
      param_r <= line_i.param;
   end

   // new bit enters at the MSB, older bits walk toward the LSB
   // so the first bit of a full-width payload ends up in bit 0
   if (width_lp > 1)
   begin : g_shift
      assign data_shift = {param_r, data_r[width_lp-1:1]};
   end
   else
   begin : g_shift
      assign data_shift = param_r;
   end

   // reset code and idle both leave the value alone
   always_ff @(posedge bsg_tag_i)
   begin
      if (op_r)
         data_r <= data_shift;
   end

   // changes two cycles after the line does
   assign data_async_r_o = data_r;

endmodule

// File: design/tag_line_pkg.sv
// line codes: op high shifts param in, op low with param high is client reset
// both low is idle; a line is a plain level with no handshake
`include "tag_net_consts.svh"

package tag_line_pkg;

   // one serial line from the master to a client
   typedef struct packed
   {
      logic op;
      logic param;
   } tag_line_s;

   // what one receive stage hands to the user
   // data only moves when new_val pulses
   typedef struct packed
   {
      logic [`TAG_CLIENT_W-1:0] data;
      logic                     new_val;
      logic                     client_reset;
   } tag_client_out_s;

endpackage

// File: design/tag_master.sv
// one stream bit per cycle with no valid; a 1 seen while idle starts a packet
// node ids at or above TAG_NUM_CLIENTS are parsed but drive no line
`timescale 1ns/1ps
`include "tag_net_consts.svh"

module tag_master
   (
      input  logic                                              bsg_tag_i,
      input  logic                                              reset_i,
      input  logic                                              tag_bit_i,
      output tag_line_pkg::tag_line_s [`TAG_NUM_CLIENTS-1:0]    lines_o
   );

   localparam int hdr_w_lp     = `TAG_HDR_W;
   localparam int hdr_cnt_w_lp = $clog2(hdr_w_lp);
   localparam int len_w_lp     = `TAG_LEN_W;
   localparam int node_w_lp    = `TAG_NODE_W;

   tag_pkt_pkg::tag_master_state_e state_r, state_n;

   // header shift register, fully valid once the last header bit is in
   tag_pkt_pkg::tag_hdr_s hdr_r, hdr_n;

   logic [hdr_cnt_w_lp-1:0] hdr_cnt_r;
   logic [len_w_lp-1:0]     len_cnt_r;

   tag_line_pkg::tag_line_s [`TAG_NUM_CLIENTS-1:0] lines_r, lines_n;

   // per line non-idle flags, for the one-hot check
   logic [`TAG_NUM_CLIENTS-1:0] busy;

   // header with the current bit shifted in at the LSB
   assign hdr_n = tag_pkt_pkg::tag_hdr_s'({hdr_r[hdr_w_lp-2:0], tag_bit_i});

   // this cycle carries the final header bit
   wire hdr_last = (hdr_cnt_r == hdr_cnt_w_lp'(hdr_w_lp - 1));

   // this cycle carries the final payload bit
   wire pay_last = (len_cnt_r == len_w_lp'(1));

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         tag_pkt_pkg::e_idle:
         begin
            if (tag_bit_i)
               state_n = tag_pkt_pkg::e_header;
         end
         tag_pkt_pkg::e_header:
         begin
            // zero length skips straight back, no line activity
            if (hdr_last)
               state_n = (hdr_n.len == '0) ? tag_pkt_pkg::e_idle
                                           : tag_pkt_pkg::e_payload;
         end
         tag_pkt_pkg::e_payload:
         begin
            // back in idle next cycle, so a start bit can follow directly
            if (pay_last)
               state_n = tag_pkt_pkg::e_idle;
         end
         default:
            state_n = tag_pkt_pkg::e_idle;
      endcase
   end

   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
         // partial packets are dropped
         state_r <= tag_pkt_pkg::e_idle;
      else
         state_r <= state_n;
   end

   // header and payload counters
   // only meaningful in the state that loads them
   always_ff @(posedge bsg_tag_i)
   begin
      if (state_r == tag_pkt_pkg::e_header)
         hdr_cnt_r <= hdr_cnt_r + 1'b1;
      else
         hdr_cnt_r <= '0;

      if (state_r == tag_pkt_pkg::e_header)
         hdr_r <= hdr_n;

      if ((state_r == tag_pkt_pkg::e_header) && hdr_last)
         len_cnt_r <= hdr_n.len;
      else if (state_r == tag_pkt_pkg::e_payload)
         len_cnt_r <= len_cnt_r - 1'b1;
   end

   // next line values; only the addressed node leaves idle
   always_comb
   begin
      lines_n = '0;
      if (state_r == tag_pkt_pkg::e_payload)
      begin
         for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
         begin
            if (hdr_r.node == node_w_lp'(i))
            begin
               // data: op high, param carries the bit
               // reset: op low, param high, payload bit ignored
               lines_n[i].op    = hdr_r.data_not_reset;
               lines_n[i].param = hdr_r.data_not_reset ? tag_bit_i : 1'b1;
            end
         end
      end
   end

   // bit sampled at edge t shows up on the line right after t
   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
         lines_r <= '0;
      else
         lines_r <= lines_n;
   end

   assign lines_o = lines_r;

   always_comb
   begin
      for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
         busy[i] = lines_r[i].op | lines_r[i].param;
   end

   // clients see at most one active line per cycle
   a_one_line: assert property (@(posedge bsg_tag_i) disable iff (reset_i)
      $onehot0(busy))
      else $error("tag_master drives more than one line");

endmodule

// File: design/tag_net_consts.svh
// sizing for the tag network; node id width must cover TAG_NUM_CLIENTS
// TAG_HDR_W is derived, so change node or length width and not the sum
`ifndef TAG_NET_CONSTS_SVH
`define TAG_NET_CONSTS_SVH

// number of client nodes hanging off the master
`define TAG_NUM_CLIENTS 4

// bits held by each client register
`define TAG_CLIENT_W 8

// node id field width in the packet header
`define TAG_NODE_W 2

// payload length field width, so 0 to 15 payload bits
`define TAG_LEN_W 4

// header bits that follow the start bit:
// node id, then data_not_reset, then length
`define TAG_HDR_W (`TAG_NODE_W + 1 + `TAG_LEN_W)

`endif

// File: design/tag_net_top.sv
// one master feeding TAG_NUM_CLIENTS client pairs, all on bsg_tag_i
// tag_bit_i carries one bit per cycle with zeros as idle
`timescale 1ns/1ps
`include "tag_net_consts.svh"

module tag_net_top
   (
      input  logic                                                bsg_tag_i,
      input  logic                                                reset_i,
      input  logic                                                tag_bit_i,
      output tag_line_pkg::tag_client_out_s [`TAG_NUM_CLIENTS-1:0] clients_o
   );

   // one op/param line per client
   tag_line_pkg::tag_line_s [`TAG_NUM_CLIENTS-1:0] lines_w;

   // raw shift register contents, per client
   logic [`TAG_NUM_CLIENTS-1:0][`TAG_CLIENT_W-1:0] data_async_w;

   tag_master master0
      (
         .bsg_tag_i (bsg_tag_i),
         .reset_i   (reset_i),
         .tag_bit_i (tag_bit_i),
         .lines_o   (lines_w)
      );

   for (genvar i = 0; i < `TAG_NUM_CLIENTS; i++)
   begin : g_client
      // shift side
      tag_client_unsync unsync0
         (
            .bsg_tag_i      (bsg_tag_i),
            .line_i         (lines_w[i]),
            .data_async_r_o (data_async_w[i])
         );

      // receive side sees the same line as the shift side
      tag_client_recv recv0
         (
            .bsg_tag_i    (bsg_tag_i),
            .reset_i      (reset_i),
            .line_i       (lines_w[i]),
            .data_async_i (data_async_w[i]),
            .client_o     (clients_o[i])
         );
   end

endmodule

// File: design/tag_pkt_pkg.sv
// packet layout is start bit, node, data_not_reset, len, payload
// all header fields arrive MSB first
`include "tag_net_consts.svh"

package tag_pkt_pkg;

   // header as it sits after TAG_HDR_W shifts
   // field order matches the wire order, node first
   typedef struct packed
   {
      // addressed client
      logic [`TAG_NODE_W-1:0] node;
      // 1 = shift payload in, 0 = hold client in reset
      logic                   data_not_reset;
      // payload cycles that follow, zero means none
      logic [`TAG_LEN_W-1:0]  len;
   } tag_hdr_s;

   // master parser states
   typedef enum logic [1:0]
   {
      // waiting for a start bit, zeros are idle
      e_idle    = 2'd0,
      // collecting header bits
      e_header  = 2'd1,
      // forwarding payload to one line
      e_payload = 2'd2
   } tag_master_state_e;

endpackage

// File: flist.f
+incdir+design
design/tag_line_pkg.sv
design/tag_pkt_pkg.sv
design/tag_master.sv
design/tag_client_unsync.sv
design/tag_client_recv.sv
design/tag_net_top.sv
verif/tag_net_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tag network testbench with Verilator
# exits non-zero on a build error, a simulator error or a reported failure

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tag_net_tb \
   -f flist.f \
   --Mdir "$BUILD_DIR" \
   -o sim_tag_net
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

"./$BUILD_DIR/sim_tag_net" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
   echo "failure reported, see $LOG"
   exit 1
fi

echo "run finished, log in $LOG"
exit 0

// File: verif/tag_net_tb.sv
// single clock; client data is unknown until test 2 has shifted a full width into every node
// the expected values come from a shift model kept here, fed by the same packet fields
`timescale 1ns/1ps
`include "tag_net_consts.svh"

module tag_net_tb;

   localparam int num_lp        = `TAG_NUM_CLIENTS;
   localparam int width_lp      = `TAG_CLIENT_W;
   localparam int node_w_lp     = `TAG_NODE_W;
   localparam int len_w_lp      = `TAG_LEN_W;
   localparam int hdr_w_lp      = `TAG_HDR_W;
   localparam int rand_pkts_lp  = 40;
   localparam int reset_pkts_lp = 8;
   localparam int zero_pkts_lp  = 6;
   localparam int b2b_pkts_lp   = 12;
   localparam int pkt_total_lp  = num_lp + rand_pkts_lp + 2 * reset_pkts_lp
                                  + zero_pkts_lp + b2b_pkts_lp;
   localparam int watchdog_cycles_lp = pkt_total_lp * (hdr_w_lp + 16 + 6) + 100;
   // new_val lands a few cycles after the last bit
   localparam int wait_cycles_lp   = 20;
   localparam int settle_cycles_lp = 8;

   logic bsg_tag_i;
   logic reset_i;
   logic tag_bit_i;
   tag_line_pkg::tag_client_out_s [num_lp-1:0] clients_o;

   // model: one shift value per client
   logic [width_lp-1:0] shift_val [num_lp];
   logic [width_lp-1:0] full_payload [num_lp];
   logic                model_valid;

   // expected and observed new_val events, in order
   int                  exp_node_q[$];
   logic [width_lp-1:0] exp_data_q[$];
   int                  obs_node_q[$];
   logic [width_lp-1:0] obs_data_q[$];

   // reset pulses and high cycles per client
   int exp_rst [num_lp];
   int obs_rst [num_lp];
   int exp_rst_cyc [num_lp];
   int obs_rst_cyc [num_lp];

   logic [num_lp-1:0]   rst_prev;
   logic [width_lp-1:0] data_prev [num_lp];

   int errors;
   int checks;
   int tests_run;
   int test_err_start;

   tag_net_top dut0
      (
         .bsg_tag_i (bsg_tag_i),
         .reset_i   (reset_i),
         .tag_bit_i (tag_bit_i),
         .clients_o (clients_o)
      );

   always #4 bsg_tag_i = ~bsg_tag_i;

   // monitor samples at the falling edge, away from the update edge
   always @(negedge bsg_tag_i)
   begin
      for (int c = 0; c < num_lp; c++)
      begin
         if (!reset_i)
         begin
            if (clients_o[c].new_val)
            begin
               obs_node_q.push_back(c);
               obs_data_q.push_back(clients_o[c].data);
            end
            else if (clients_o[c].data !== data_prev[c])
            begin
               $display("error at %0t: node %0d data moved without new_val", $time, c);
               errors++;
            end
            if (clients_o[c].client_reset)
            begin
               obs_rst_cyc[c]++;
               // count rising edges as pulses
               if (!rst_prev[c])
                  obs_rst[c]++;
            end
         end
         rst_prev[c]  = clients_o[c].client_reset;
         data_prev[c] = clients_o[c].data;
      end
   end

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                            input string msg);
      checks++;
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
         errors++;
      end
   endtask

   // one stream bit per cycle
   task automatic drive_bit(input logic b);
      @(posedge bsg_tag_i);
      tag_bit_i <= b;
   endtask

   function automatic int pick_gap();
      return int'($urandom_range(0, 5));
   endfunction

   task automatic clear_expect();
      exp_node_q.delete();
      exp_data_q.delete();
      obs_node_q.delete();
      obs_data_q.delete();
      for (int c = 0; c < num_lp; c++)
      begin
         exp_rst[c]     = 0;
         obs_rst[c]     = 0;
         exp_rst_cyc[c] = 0;
         obs_rst_cyc[c] = 0;
      end
   endtask

   // start bit, header MSB first, payload bit 0 first, then idle gap
   task automatic send_packet(input int node, input logic dnr, input int len,
                              input logic [15:0] payload, input int gap);
      logic [hdr_w_lp-1:0] hdr;
      hdr = {node_w_lp'(node), dnr, len_w_lp'(len)};
      drive_bit(1'b1);
      for (int i = hdr_w_lp - 1; i >= 0; i--)
         drive_bit(hdr[i]);
      for (int i = 0; i < len; i++)
         drive_bit(payload[i]);
      // zero length leaves the model alone
      if ((len > 0) && dnr)
      begin
         // newest bit in the MSB, older ones move toward the LSB
         for (int i = 0; i < len; i++)
            shift_val[node] = {payload[i], shift_val[node][width_lp-1:1]};
         exp_node_q.push_back(node);
         exp_data_q.push_back(shift_val[node]);
      end
      else if (len > 0)
      begin
         exp_rst[node]++;
         exp_rst_cyc[node] += len;
      end
      repeat (gap) drive_bit(1'b0);
   endtask

   task automatic start_test();
      test_err_start = errors;
      clear_expect();
   endtask

   // wait for the expected new_val events, then compare everything seen
   task automatic drain_events();
      int waited;
      int n;
      drive_bit(1'b0);
      waited = 0;
      while ((obs_node_q.size() < exp_node_q.size()) && (waited < wait_cycles_lp))
      begin
         @(posedge bsg_tag_i);
         waited++;
      end
      if (obs_node_q.size() < exp_node_q.size())
      begin
         $display("error at %0t: timed out waiting for new_val, saw %0d of %0d",
                  $time, obs_node_q.size(), exp_node_q.size());
         errors++;
      end
      // room for any stray event to show up
      repeat (settle_cycles_lp) @(posedge bsg_tag_i);
      @(negedge bsg_tag_i);
      check_val(32'(obs_node_q.size()), 32'(exp_node_q.size()), "new_val count");
      n = (obs_node_q.size() < exp_node_q.size()) ? obs_node_q.size() : exp_node_q.size();
      for (int k = 0; k < n; k++)
      begin
         check_val(32'(obs_node_q[k]), 32'(exp_node_q[k]),
                   $sformatf("new_val %0d node", k));
         check_val(32'(obs_data_q[k]), 32'(exp_data_q[k]),
                   $sformatf("new_val %0d data on node %0d", k, exp_node_q[k]));
      end
      for (int c = 0; c < num_lp; c++)
      begin
         check_val(32'(obs_rst[c]), 32'(exp_rst[c]),
                   $sformatf("client_reset pulses on node %0d", c));
         check_val(32'(obs_rst_cyc[c]), 32'(exp_rst_cyc[c]),
                   $sformatf("client_reset cycles on node %0d", c));
         if (model_valid)
            check_val(32'(clients_o[c].data), 32'(shift_val[c]),
                      $sformatf("held data on node %0d", c));
      end
   endtask

   task automatic report_test(input int num, input string name);
      tests_run++;
      $display("test %0d %s: %0d errors", num, name, errors - test_err_start);
   endtask

   initial
   begin
      int          node;
      int          len;
      logic [15:0] payload;
      void'($urandom(32'h1664_dc4a));
      bsg_tag_i   = 1'b0;
      reset_i     = 1'b1;
      tag_bit_i   = 1'b0;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      model_valid = 1'b0;
      rst_prev    = '0;
      clear_expect();
      repeat (2) @(posedge bsg_tag_i);
      reset_i <= 1'b0;

      // outputs quiet straight out of reset
      start_test();
      repeat (10)
      begin
         @(negedge bsg_tag_i);
         for (int c = 0; c < num_lp; c++)
         begin
            check_val(32'(clients_o[c].new_val), 32'd0, $sformatf("node %0d new_val", c));
            check_val(32'(clients_o[c].client_reset), 32'd0,
                      $sformatf("node %0d client_reset", c));
         end
      end
      drain_events();
      report_test(1, "quiet after reset");

      // full width into each node defines every shift value
      start_test();
      for (int c = 0; c < num_lp; c++)
      begin
         payload = 16'($urandom);
         full_payload[c] = payload[width_lp-1:0];
         send_packet(c, 1'b1, width_lp, payload, pick_gap());
      end
      model_valid = 1'b1;
      drain_events();
      // first bit sent must sit in the LSB
      for (int c = 0; c < num_lp; c++)
         check_val(32'(clients_o[c].data), 32'(full_payload[c]),
                   $sformatf("node %0d full payload", c));
      report_test(2, "full width per node");

      start_test();
      repeat (rand_pkts_lp)
      begin
         node    = int'($urandom_range(0, num_lp - 1));
         len     = int'($urandom_range(1, 15));
         payload = 16'($urandom);
         send_packet(node, 1'b1, len, payload, pick_gap());
      end
      drain_events();
      report_test(3, "random data packets");

      // reset then data on the same node
      start_test();
      repeat (reset_pkts_lp)
      begin
         node    = int'($urandom_range(0, num_lp - 1));
         len     = int'($urandom_range(1, 15));
         payload = 16'($urandom);
         send_packet(node, 1'b0, len, payload, pick_gap());
         len     = int'($urandom_range(1, 15));
         payload = 16'($urandom);
         send_packet(node, 1'b1, len, payload, pick_gap());
      end
      drain_events();
      report_test(4, "reset packets");

      // zero length first, then a burst with no idle between packets
      start_test();
      repeat (zero_pkts_lp)
      begin
         node    = int'($urandom_range(0, num_lp - 1));
         payload = 16'($urandom);
         send_packet(node, 1'($urandom), 0, payload, pick_gap());
      end
      repeat (b2b_pkts_lp)
      begin
         node    = int'($urandom_range(0, num_lp - 1));
         len     = int'($urandom_range(1, 15));
         payload = 16'($urandom);
         send_packet(node, 1'b1, len, payload, 0);
      end
      drain_events();
      report_test(5, "zero length and back to back");

      $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // bound on the whole run, sized from the packet count
   initial
   begin
      repeat (watchdog_cycles_lp) @(posedge bsg_tag_i);
      $display("watchdog expired after %0d cycles, the run did not finish",
               watchdog_cycles_lp);
      $display("Simulation FAILED");
      $finish;
   end

endmodule
